//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // first fetch address after reset
  localparam word_t reset_pc = '0;

  // major opcodes kept by the core
  typedef enum logic [6:0] {
    op_load    = 7'b00_000_11,
    op_store   = 7'b01_000_11,
    op_branch  = 7'b11_000_11,
    op_jalr    = 7'b11_001_11,
    op_jal     = 7'b11_011_11,
    op_reg_imm = 7'b00_100_11,
    op_reg_reg = 7'b01_100_11,
    op_environ = 7'b11_100_11,
    op_auipc   = 7'b00_101_11,
    op_lui     = 7'b01_101_11
  } opcode_e;

  // arithmetic ops first, then the branch compares
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  typedef enum logic [3:0] {
    cls_alu_reg, cls_alu_imm, cls_lui, cls_auipc, cls_branch, cls_jal,
    cls_jalr, cls_load, cls_store, cls_ecall, cls_illegal
  } insn_class_e;

  typedef struct packed {
    insn_class_e cls;
    alu_op_e     alu_op;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    word_t       imm;
  } decoded_t;

  typedef struct packed {
    logic  re;
    logic  we;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [2**reg_addr_w];

  // combinational read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      // x0 never written, stays zero from reset
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- src/insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decode (
  input  rv_pkg::word_t    insn,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // immediates per format, sign bit is always insn[31]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    dec.cls    = cls_illegal;
    dec.alu_op = alu_add;
    dec.rd     = insn[11:7];
    dec.rs1    = insn[19:15];
    dec.rs2    = insn[24:20];
    dec.imm    = imm_i;
    case (opcode)
      op_lui: begin
        dec.cls = cls_lui;
        dec.imm = imm_u;
      end
      op_auipc: begin
        dec.cls = cls_auipc;
        dec.imm = imm_u;
      end
      op_jal: begin
        dec.cls = cls_jal;
        dec.imm = imm_j;
      end
      op_jalr: begin
        if (funct3 == 3'b000) dec.cls = cls_jalr;
      end
      op_branch: begin
        dec.cls = cls_branch;
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.alu_op = alu_eq;
          3'b001:  dec.alu_op = alu_ne;
          3'b100:  dec.alu_op = alu_lt;
          3'b101:  dec.alu_op = alu_ge;
          3'b110:  dec.alu_op = alu_ltu;
          3'b111:  dec.alu_op = alu_geu;
          default: dec.cls = cls_illegal;
        endcase
      end
      op_load: begin
        // word access only
        if (funct3 == 3'b010) dec.cls = cls_load;
      end
      op_store: begin
        dec.imm = imm_s;
        if (funct3 == 3'b010) dec.cls = cls_store;
      end
      op_reg_imm, op_reg_reg: begin
        dec.cls = (opcode == op_reg_imm) ? cls_alu_imm : cls_alu_reg;
        case (funct3)
          3'b000:  dec.alu_op = (opcode == op_reg_reg && funct7[5]) ? alu_sub : alu_add;
          3'b001:  dec.alu_op = alu_sll;
          3'b010:  dec.alu_op = alu_slt;
          3'b011:  dec.alu_op = alu_sltu;
          3'b100:  dec.alu_op = alu_xor;
          3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;
          3'b110:  dec.alu_op = alu_or;
          default: dec.alu_op = alu_and;
        endcase
        // funct7 only checked where it is part of the encoding
        if ((opcode == op_reg_reg || funct3 == 3'b001 || funct3 == 3'b101) &&
            ({funct7[6], funct7[4:0]} != 6'b0 ||
             (funct7[5] && funct3 != 3'b101 &&
              !(opcode == op_reg_reg && funct3 == 3'b000)))) begin
          dec.cls = cls_illegal;
        end
      end
      op_environ: begin
        if (insn[31:7] == '0) dec.cls = cls_ecall;
      end
      default: dec.cls = cls_illegal;
    endcase
  end

endmodule

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    result,
  output logic             taken
);
  import rv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;
  logic       signed_lt;
  logic       unsigned_lt;

  // immediate operand also forms load/store/jalr addresses
  always_comb begin
    case (dec.cls)
      cls_alu_imm, cls_load, cls_store, cls_jalr: op_b = dec.imm;
      default:                                    op_b = rs2_data;
    endcase
  end

  assign shamt       = op_b[4:0];
  assign signed_lt   = $signed(rs1_data) < $signed(op_b);
  assign unsigned_lt = rs1_data < op_b;

  always_comb begin
    case (dec.alu_op)
      alu_add:  result = rs1_data + op_b;
      alu_sub:  result = rs1_data - op_b;
      alu_sll:  result = rs1_data << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, signed_lt};
      alu_sltu: result = {{(xlen-1){1'b0}}, unsigned_lt};
      alu_xor:  result = rs1_data ^ op_b;
      alu_srl:  result = rs1_data >> shamt;
      alu_sra:  result = word_t'($signed(rs1_data) >>> shamt);
      alu_or:   result = rs1_data | op_b;
      alu_and:  result = rs1_data & op_b;
      default:  result = '0;
    endcase
  end

  // branch condition, zero for anything else
  always_comb begin
    case (dec.alu_op)
      alu_eq:  taken = (rs1_data == op_b);
      alu_ne:  taken = (rs1_data != op_b);
      alu_lt:  taken = signed_lt;
      alu_ge:  taken = !signed_lt;
      alu_ltu: taken = unsigned_lt;
      alu_geu: taken = !unsigned_lt;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/core_control.sv
`timescale 1ns/1ps
`default_nettype none

module core_control (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::decoded_t  dec,
  input  rv_pkg::word_t     alu_result,
  input  logic              taken,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::word_t     dmem_rdata,
  output logic              imem_req,
  output rv_pkg::word_t     imem_addr,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              rf_we,
  output rv_pkg::reg_idx_t  rf_rd,
  output rv_pkg::word_t     rf_data,
  output logic              halt
);
  import rv_pkg::*;

  // idle covers the reset cycles, so no request goes out while rst is high
  typedef enum logic [2:0] {
    st_idle, st_fetch, st_execute, st_load_wb, st_halted
  } state_e;

  state_e   state;
  state_e   state_next;
  word_t    pc;
  word_t    pc_next;
  word_t    pc_plus4;
  word_t    pc_imm;
  reg_idx_t load_rd;
  logic     writes_rd;

  assign pc_plus4 = pc + word_t'(4);
  assign pc_imm   = pc + dec.imm;

  always_comb begin
    case (dec.cls)
      cls_alu_reg, cls_alu_imm, cls_lui, cls_auipc, cls_jal, cls_jalr: writes_rd = 1'b1;
      default: writes_rd = 1'b0;
    endcase
  end

  always_comb begin
    state_next = state;
    pc_next    = pc;
    case (state)
      st_idle:  state_next = st_fetch;
      st_fetch: state_next = st_execute;
      st_execute: begin
        state_next = st_fetch;
        pc_next    = pc_plus4;
        case (dec.cls)
          cls_branch: if (taken) pc_next = pc_imm;
          cls_jal:    pc_next = pc_imm;
          cls_jalr:   pc_next = {alu_result[xlen-1:1], 1'b0};
          cls_load: begin
            // pc moves on in load_wb
            state_next = st_load_wb;
            pc_next    = pc;
          end
          cls_ecall, cls_illegal: begin
            state_next = st_halted;
            pc_next    = pc;
          end
          default: pc_next = pc_plus4;
        endcase
      end
      st_load_wb: begin
        state_next = st_fetch;
        pc_next    = pc_plus4;
      end
      default: state_next = st_halted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      pc    <= reset_pc;
    end else begin
      state <= state_next;
      pc    <= pc_next;
    end
  end

  // keep load destination, insn is not guaranteed in load_wb
  always_ff @(posedge clk) begin
    if (state == st_execute) begin
      load_rd <= dec.rd;
    end
  end

  assign imem_req  = (state == st_fetch);
  assign imem_addr = pc;
  assign halt      = (state == st_halted);

  always_comb begin
    dmem_req.re    = (state == st_execute) && (dec.cls == cls_load);
    dmem_req.we    = (state == st_execute) && (dec.cls == cls_store);
    dmem_req.addr  = alu_result;
    dmem_req.wdata = rs2_data;
  end

  assign rf_we = ((state == st_execute) && writes_rd) || (state == st_load_wb);
  assign rf_rd = (state == st_load_wb) ? load_rd : dec.rd;

  // writeback source
  always_comb begin
    if (state == st_load_wb) begin
      rf_data = dmem_rdata;
    end else begin
      case (dec.cls)
        cls_lui:           rf_data = dec.imm;
        cls_auipc:         rf_data = pc_imm;
        cls_jal, cls_jalr: rf_data = pc_plus4;
        default:           rf_data = alu_result;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     insn,
  input  rv_pkg::word_t     dmem_rdata,
  output logic              imem_req,
  output rv_pkg::word_t     imem_addr,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              halt
);
  import rv_pkg::*;

  decoded_t dec;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_result;
  logic     taken;
  logic     rf_we;
  reg_idx_t rf_rd;
  word_t    rf_data;

  insn_decode u_insn_decode (
    .insn (insn),
    .dec  (dec)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .we       (rf_we),
    .rd       (rf_rd),
    .rd_data  (rf_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result),
    .taken    (taken)
  );

  core_control u_core_control (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec),
    .alu_result (alu_result),
    .taken      (taken),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .dmem_req   (dmem_req),
    .rf_we      (rf_we),
    .rf_rd      (rf_rd),
    .rf_data    (rf_data),
    .halt       (halt)
  );

endmodule

`default_nettype wire

//--- verif/rv_model.svh
`ifndef rv_model_svh
`define rv_model_svh

logic [31:0] lcg_state;
word_t       model_mem [mem_words];
int          prog_pos;

function automatic logic [31:0] rand_below(input int unsigned n);
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  // low bits of the lcg repeat quickly
  return (lcg_state >> 8) % n;
endfunction

function automatic reg_idx_t pick_reg();
  reg_idx_t r;
  r = reg_idx_t'(rand_below(14));
  // x1 holds the data base, x14 takes its place
  return (r == 5'd1) ? 5'd14 : r;
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd, input opcode_e op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, op_reg_reg};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                input reg_idx_t rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
endfunction

function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                input reg_idx_t rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

function automatic word_t alu_calc(input logic [2:0] f3, input logic alt,
                                   input word_t a, input word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 1 : 0;
    3'd3: return (a < b) ? 1 : 0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) return $signed(a) >>> b[4:0];
      else return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    default: return a >= b;
  endcase
endfunction

task automatic emit(input word_t w);
  mem[prog_pos] = w;
  prog_pos++;
endtask

task automatic build_program();
  int          kind;
  int          span;
  int          tgt;
  int          off;
  int          idx;
  int          br_count;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] imm;
  logic        is_target [prog_len];
  lcg_state = seed;
  for (int i = 0; i < mem_words; i++) begin
    mem[i] = (i * 32'h0001_0003) ^ 32'h5a00_00a5;
  end
  foreach (is_target[t]) is_target[t] = 1'b0;
  prog_pos = 0;
  br_count = 0;
  emit(enc_i(data_base[11:0], 5'd0, 3'b000, 5'd1, op_reg_imm));
  while (prog_pos < prog_len - 1) begin
    kind = rand_below(16);
    span = prog_len - 1 - prog_pos;
    if (span > 4) span = 4;
    // no jump may land on a jalr and skip the addi that sets x15
    if (kind == 13 && prog_pos <= prog_len - 3 && !is_target[prog_pos + 1]) begin
      // x15 plus offset lands on the target, sometimes with bit 0 set
      span = prog_len - 2 - prog_pos;
      if (span > 4) span = 4;
      tgt = prog_pos + 2 + rand_below(span);
      off = rand_below(4);
      is_target[tgt] = 1'b1;
      emit(enc_i(12'(tgt * 4 + rand_below(2) - off), 5'd0, 3'b000, 5'd15, op_reg_imm));
      emit(enc_i(12'(off), 5'd15, 3'b000, pick_reg(), op_jalr));
    end else begin
      case (kind)
        4: emit(enc_i(12'(4 * rand_below(16)), 5'd1, 3'b010, pick_reg(), op_load));
        5, 6: begin
          f3 = 3'(rand_below(8));
          f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) != 0) ? 7'h20 : 7'h00;
          emit(enc_r(f7, pick_reg(), pick_reg(), f3, pick_reg()));
        end
        7, 8, 15: begin
          f3 = 3'(rand_below(8));
          imm = 12'(rand_below(4096));
          if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
          if (f3 == 3'd5) imm = {(rand_below(2) != 0) ? 7'h20 : 7'h00, imm[4:0]};
          emit(enc_i(imm, pick_reg(), f3, pick_reg(), op_reg_imm));
        end
        9:  emit({20'(rand_below(1 << 20)), pick_reg(), op_lui});
        10: emit({20'(rand_below(1 << 20)), pick_reg(), op_auipc});
        11, 14: begin
          // walk through the six compares in turn
          idx = br_count % 6;
          br_count++;
          f3 = (idx < 2) ? 3'(idx) : 3'(idx + 2);
          off = 4 * (1 + rand_below(span));
          is_target[prog_pos + off / 4] = 1'b1;
          emit(enc_b(13'(off), pick_reg(), pick_reg(), f3));
        end
        12: begin
          off = 4 * (1 + rand_below(span));
          is_target[prog_pos + off / 4] = 1'b1;
          emit(enc_j(21'(off), pick_reg()));
        end
        default: emit(enc_s(12'(4 * rand_below(16)), pick_reg(), 5'd1));
      endcase
    end
  end
  emit(enc_i(12'd0, 5'd0, 3'b000, 5'd0, op_environ));
endtask

// instruction-set model, fills the expected fetch, load and store queues
task automatic run_model();
  word_t x [32];
  word_t pc;
  word_t npc;
  word_t w;
  word_t a;
  word_t b;
  word_t addr;
  word_t wv;
  word_t imm_i;
  word_t imm_s;
  logic  done;
  int    steps;
  int    gap;
  foreach (x[r]) x[r] = '0;
  model_mem = mem;
  pc = reset_pc;
  done = 1'b0;
  steps = 0;
  while (!done && steps < 1000) begin
    w = model_mem[pc[10:2]];
    exp_fetch.push_back(pc);
    a = x[w[19:15]];
    b = x[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    npc = pc + 4;
    wv = '0;
    gap = 2;
    case (w[6:0])
      op_lui:   wv = {w[31:12], 12'd0};
      op_auipc: wv = pc + {w[31:12], 12'd0};
      op_jal: begin
        wv = pc + 4;
        npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      op_jalr: begin
        wv = pc + 4;
        npc = (a + imm_i) & ~32'd1;
      end
      op_branch: begin
        if (branch_taken(w[14:12], a, b)) begin
          npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      op_load: begin
        addr = a + imm_i;
        exp_ld_addr.push_back(addr);
        wv = model_mem[addr[10:2]];
        // load writeback adds a cycle before the next fetch
        gap = 3;
      end
      op_store: begin
        addr = a + imm_s;
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(b);
        model_mem[addr[10:2]] = b;
      end
      op_reg_imm: wv = alu_calc(w[14:12], w[14:12] == 3'd5 && w[30], a, imm_i);
      op_reg_reg: wv = alu_calc(w[14:12], w[30], a, b);
      default:    done = 1'b1;
    endcase
    // branches and stores have no rd
    if (w[6:0] != op_branch && w[6:0] != op_store && w[11:7] != 5'd0) begin
      x[w[11:7]] = wv;
    end
    if (!done) exp_gap.push_back(gap);
    pc = npc;
    steps++;
  end
endtask

`endif

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam int    seed           = 61;
  localparam int    prog_len       = 40;
  localparam int    mem_words      = 512;
  localparam word_t data_base      = 32'h0000_0400;
  localparam int    timeout_cycles = 2000;
  localparam int    halt_window    = 20;

  logic      clk;
  logic      rst;
  word_t     insn;
  word_t     dmem_rdata;
  logic      imem_req;
  word_t     imem_addr;
  dmem_req_t dmem_req;
  logic      halt;

  // program and data share one array
  word_t mem [mem_words];
  word_t exp_fetch [$];
  word_t exp_ld_addr [$];
  word_t exp_st_addr [$];
  word_t exp_st_data [$];
  int    exp_gap [$];
  int    errors;
  int    checks;
  int    since_fetch;
  logic  fetch_seen;

  `include "rv_model.svh"

  rv_core u_rv_core (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .dmem_rdata (dmem_rdata),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .dmem_req   (dmem_req),
    .halt       (halt)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_idle(input string name);
    check_value({name, "_imem_req"}, 0, imem_req);
    check_value({name, "_dmem_re"}, 0, dmem_req.re);
    check_value({name, "_dmem_we"}, 0, dmem_req.we);
    check_value({name, "_halt"}, 0, halt);
  endtask

  // memory answers one cycle after each request
  always @(posedge clk) begin
    if (imem_req) insn <= mem[imem_addr[10:2]];
    if (dmem_req.re) dmem_rdata <= mem[dmem_req.addr[10:2]];
    if (dmem_req.we) mem[dmem_req.addr[10:2]] <= dmem_req.wdata;
  end

  // requests compared against the model mid-cycle
  always @(negedge clk) begin
    if (!rst) since_fetch++;
    if (!rst && imem_req) begin
      if (exp_fetch.size() == 0) begin
        errors++;
        $display("fetch at %h after the last expected instruction", imem_addr);
      end else begin
        check_value("fetch_addr", exp_fetch.pop_front(), imem_addr);
        // cycles since the previous fetch, 3 after a load
        if (fetch_seen) begin
          check_value("fetch_gap", exp_gap.pop_front(), since_fetch);
        end
      end
      fetch_seen = 1'b1;
      since_fetch = 0;
    end
    if (!rst && dmem_req.re) begin
      if (exp_ld_addr.size() == 0) begin
        errors++;
        $display("load from %h that the model does not expect", dmem_req.addr);
      end else begin
        check_value("load_addr", exp_ld_addr.pop_front(), dmem_req.addr);
      end
    end
    if (!rst && dmem_req.we) begin
      if (exp_st_addr.size() == 0) begin
        errors++;
        $display("store to %h that the model does not expect", dmem_req.addr);
      end else begin
        check_value("store_addr", exp_st_addr.pop_front(), dmem_req.addr);
        check_value("store_data", exp_st_data.pop_front(), dmem_req.wdata);
      end
    end
  end

  initial begin : main
    int cycles;
    errors = 0;
    checks = 0;
    since_fetch = 0;
    fetch_seen = 1'b0;
    rst = 1'b1;
    insn = '0;
    dmem_rdata = '0;
    build_program();
    run_model();
    @(posedge clk);
    @(negedge clk);
    check_idle("reset");
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle("reset_release");
    @(negedge clk);
    check_value("first_fetch", 1, imem_req);
    cycles = 0;
    while (!halt && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      errors++;
      $display("core did not halt within %0d cycles", timeout_cycles);
    end
    // nothing may move once halted
    for (int i = 0; i < halt_window; i++) begin
      @(negedge clk);
      check_value("halt_hold", 1, halt);
      check_value("halt_imem_req", 0, imem_req);
      check_value("halt_dmem_re", 0, dmem_req.re);
      check_value("halt_dmem_we", 0, dmem_req.we);
    end
    @(posedge clk);
    check_value("fetches_left", 0, exp_fetch.size());
    check_value("loads_left", 0, exp_ld_addr.size());
    check_value("stores_left", 0, exp_st_addr.size());
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verif
src/rv_pkg.sv
src/reg_file.sv
src/insn_decode.sv
src/alu.sv
src/core_control.sv
src/rv_core.sv
verif/tb_rv_core.sv
